// File: source/axi_mem_defines.svh
/*
 * AXI4 slave memory widths and FIFO depths
 */

`ifndef AXI_MEM_DEFINES_SVH
`define AXI_MEM_DEFINES_SVH

// ------------------------------
// AXI field widths
// ------------------------------
`define AXI_ID_W        4
`define AXI_ADDR_W      32
`define AXI_LEN_W       8
`define AXI_SIZE_W      3

// 4 bytes per beat, 32-bit data
`define AXI_BYTES_LOG2  2

// ------------------------------
// memory and buffering
// ------------------------------
// 1024 words, 4 KiB address window
`define MEM_IDX_W       10

`define CHAN_FIFO_DEPTH 2
`define R_FIFO_DEPTH    4

`endif

// File: source/axi_mem_pkg.sv
/*
 * AXI4 slave memory package
 * field, FIFO payload and memory index types, address helpers
 */

`include "axi_mem_defines.svh"

package axi_mem_pkg;

	typedef logic [`AXI_ID_W-1:0]                 axi_id_t;
	typedef logic [`AXI_ADDR_W-1:0]               axi_addr_t;
	typedef logic [`AXI_LEN_W-1:0]                axi_len_t;
	typedef logic [`AXI_SIZE_W-1:0]               axi_size_t;
	typedef logic [(8 << `AXI_BYTES_LOG2)-1:0]    axi_data_t;
	typedef logic [(1 << `AXI_BYTES_LOG2)-1:0]    axi_strb_t;
	typedef logic [`MEM_IDX_W-1:0]                mem_idx_t;
	typedef logic [1:0]                           axi_resp_t;

	localparam axi_resp_t OKAY = 2'b00;

	// AW and AR payload
	typedef struct packed {
		axi_id_t   id;
		axi_addr_t addr;
		axi_len_t  len;
		axi_size_t size;
	} addr_req_t;

	typedef struct packed {
		axi_data_t data;
		axi_strb_t strb;
		logic      last;
	} w_beat_t;

	typedef struct packed {
		axi_id_t   id;
		axi_data_t data;
		logic      last;
	} r_beat_t;

	// byte address to word index, wraps at 4 KiB
	function automatic mem_idx_t addr_to_idx(input axi_addr_t addr);
		return mem_idx_t'(addr >> `AXI_BYTES_LOG2);
	endfunction

	// INCR step, later beats are size aligned
	function automatic axi_addr_t next_beat_addr(input axi_addr_t addr, input axi_size_t size);
		axi_addr_t step;
		step = axi_addr_t'(1) << size;
		return (addr & ~(step - axi_addr_t'(1))) + step;
	endfunction

endpackage

// File: source/chan_fifo.sv
/*
 * Channel FIFO: small synchronous valid/ready ring buffer
 * with a type parameter for the payload
 */

`timescale 1ns/1ps

module chan_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 2
) (
	input  logic                         aclk,
	input  logic                         aresetn,

	input  payload_t                     in_data,
	input  logic                         in_valid,
	output logic                         in_ready,

	output payload_t                     out_data,
	output logic                         out_valid,
	input  logic                         out_ready,

	output logic [$clog2(DEPTH+1)-1:0]   free_count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t             buf_mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 push;
	logic                 pop;

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	assign in_ready   = (count != CNT_W'(DEPTH));
	assign out_valid  = (count != '0);
	assign out_data   = buf_mem[rd_ptr];
	assign free_count = CNT_W'(DEPTH) - count;

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge aclk) begin
		if (push) begin
			buf_mem[wr_ptr] <= in_data;
		end
	end

	// stalled head entry must not change
	a_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("chan_fifo head changed while stalled");

endmodule

// File: source/axi_write_engine.sv
/*
 * AXI4 write engine: walks INCR write bursts, issues strobed
 * memory writes and returns the B response
 */

`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_write_engine (
	input  logic                    aclk,
	input  logic                    aresetn,

	input  axi_mem_pkg::addr_req_t  aw_req,
	input  logic                    aw_valid,
	output logic                    aw_ready,

	input  axi_mem_pkg::w_beat_t    w_beat,
	input  logic                    w_valid,
	output logic                    w_ready,

	output axi_mem_pkg::axi_id_t    bid,
	output axi_mem_pkg::axi_resp_t  bresp,
	output logic                    bvalid,
	input  logic                    bready,

	output logic                    wr_req,
	output axi_mem_pkg::mem_idx_t   wr_idx,
	output axi_mem_pkg::axi_data_t  wr_data,
	output axi_mem_pkg::axi_strb_t  wr_strb,
	input  logic                    wr_gnt
);

	import axi_mem_pkg::*;

	localparam int NB = 1 << `AXI_BYTES_LOG2;

	logic       busy;
	axi_id_t    cur_id;
	axi_addr_t  cur_addr;
	axi_len_t   rem_len;
	axi_size_t  cur_size;

	// byte lanes a narrow beat may touch
	function automatic axi_strb_t lane_mask(input axi_addr_t addr, input axi_size_t size);
		axi_strb_t mask;
		axi_addr_t offs;
		offs = addr & axi_addr_t'(NB - 1);
		for (int b = 0; b < NB; b++) begin
			mask[b] = ((axi_addr_t'(b) >> size) == (offs >> size));
		end
		return mask;
	endfunction

	// no new burst while a response is still waiting
	assign aw_ready = !busy && !bvalid;

	assign wr_req  = busy && w_valid;
	assign wr_idx  = addr_to_idx(cur_addr);
	assign wr_data = w_beat.data;
	assign wr_strb = w_beat.strb & lane_mask(cur_addr, cur_size);

	// W beat leaves its FIFO with the granted write
	assign w_ready = wr_gnt;

	assign bid   = cur_id;
	assign bresp = OKAY;

	// ------------------------------
	// burst walk
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy   <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (aw_valid && aw_ready) begin
				busy <= 1'b1;
			end else if (wr_gnt && rem_len == '0) begin
				busy   <= 1'b0;
				bvalid <= 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (aw_valid && aw_ready) begin
			cur_id   <= aw_req.id;
			cur_addr <= aw_req.addr;
			rem_len  <= aw_req.len;
			cur_size <= aw_req.size;
		end else if (wr_gnt) begin
			cur_addr <= next_beat_addr(cur_addr, cur_size);
			rem_len  <= rem_len - 1'b1;
		end
	end

	// wlast from the master has to match the AW length
	a_wlast_match: assert property (@(posedge aclk) disable iff (!aresetn)
		wr_gnt |-> (w_beat.last == (rem_len == '0)))
		else $error("wlast disagrees with burst length");

endmodule

// File: source/axi_read_engine.sv
/*
 * AXI4 read engine: walks INCR read bursts, issues memory reads
 * and tags returning data into R beats
 */

`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_read_engine (
	input  logic                                  aclk,
	input  logic                                  aresetn,

	input  axi_mem_pkg::addr_req_t                ar_req,
	input  logic                                  ar_valid,
	output logic                                  ar_ready,

	output logic                                  rd_req,
	output axi_mem_pkg::mem_idx_t                 rd_idx,
	input  logic                                  rd_gnt,
	input  axi_mem_pkg::axi_data_t                rd_data,

	output axi_mem_pkg::r_beat_t                  r_beat,
	output logic                                  r_valid,
	input  logic [$clog2(`R_FIFO_DEPTH+1)-1:0]    r_free
);

	import axi_mem_pkg::*;

	localparam int FREE_W = $clog2(`R_FIFO_DEPTH + 1);

	logic               busy;
	axi_id_t            cur_id;
	axi_addr_t          cur_addr;
	axi_len_t           rem_len;
	axi_size_t          cur_size;

	// tag stage, rd_data arrives one cycle after the grant
	logic               p_valid;
	axi_id_t            p_id;
	logic               p_last;
	logic [FREE_W-1:0]  inflight;

	assign ar_ready = !busy;

	// the beat in the tag stage lands in the R FIFO this cycle,
	// so a new grant needs one more free slot than that
	assign inflight = FREE_W'(p_valid);
	assign rd_req   = busy && (r_free > inflight);
	assign rd_idx   = addr_to_idx(cur_addr);

	assign r_valid     = p_valid;
	assign r_beat.id   = p_id;
	assign r_beat.data = rd_data;
	assign r_beat.last = p_last;

	// ------------------------------
	// burst walk
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy    <= 1'b0;
			p_valid <= 1'b0;
		end else begin
			p_valid <= rd_gnt;
			if (ar_valid && ar_ready) begin
				busy <= 1'b1;
			end else if (rd_gnt && rem_len == '0) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (ar_valid && ar_ready) begin
			cur_id   <= ar_req.id;
			cur_addr <= ar_req.addr;
			rem_len  <= ar_req.len;
			cur_size <= ar_req.size;
		end else if (rd_gnt) begin
			cur_addr <= next_beat_addr(cur_addr, cur_size);
			rem_len  <= rem_len - 1'b1;
		end
	end

	// tag follows the granted read
	always_ff @(posedge aclk) begin
		if (rd_gnt) begin
			p_id   <= cur_id;
			p_last <= (rem_len == '0);
		end
	end

	// R FIFO must always have room for the returning beat
	a_r_room: assert property (@(posedge aclk) disable iff (!aresetn)
		r_valid |-> (r_free != '0))
		else $error("read data returned with R FIFO full");

endmodule

// File: source/mem_arbiter_ram.sv
/*
 * Round-robin arbiter in front of a single-port word memory
 * byte-strobed write, registered read
 */

`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module mem_arbiter_ram (
	input  logic                    aclk,

	input  logic                    wr_req,
	input  axi_mem_pkg::mem_idx_t   wr_idx,
	input  axi_mem_pkg::axi_data_t  wr_data,
	input  axi_mem_pkg::axi_strb_t  wr_strb,
	output logic                    wr_gnt,

	input  logic                    rd_req,
	input  axi_mem_pkg::mem_idx_t   rd_idx,
	output logic                    rd_gnt,
	output axi_mem_pkg::axi_data_t  rd_data
);

	import axi_mem_pkg::*;

	localparam int NB    = 1 << `AXI_BYTES_LOG2;
	localparam int WORDS = 1 << `MEM_IDX_W;

	axi_data_t  mem [WORDS];

	// high when the read side had the last contested or single access
	logic       last_rd = 1'b0;

	// ------------------------------
	// arbitration
	// ------------------------------
	// on a tie the side not served last wins
	assign wr_gnt = wr_req && (!rd_req || last_rd);
	assign rd_gnt = rd_req && !wr_gnt;

	always_ff @(posedge aclk) begin
		if (wr_gnt) begin
			last_rd <= 1'b0;
		end else if (rd_gnt) begin
			last_rd <= 1'b1;
		end
	end

	// ------------------------------
	// memory array
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (wr_gnt) begin
			for (int b = 0; b < NB; b++) begin
				if (wr_strb[b]) begin
					mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
	end

	// data for a granted read appears next cycle
	always_ff @(posedge aclk) begin
		if (rd_gnt) begin
			rd_data <= mem[rd_idx];
		end
	end

	// back-to-back contested cycles alternate between the two sides
	a_alternate: assert property (@(posedge aclk)
		wr_req && rd_req && $past(wr_req && rd_req) |-> (wr_gnt != $past(wr_gnt)))
		else $error("contested grant did not alternate");

endmodule

// File: source/axi_mem_slave.sv
/*
 * AXI4 slave memory top: channel FIFOs, write and read engines
 * and the arbitrated single-port memory
 */

`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_slave (
	input  logic                    aclk,
	input  logic                    aresetn,

	input  axi_mem_pkg::axi_id_t    s_awid,
	input  axi_mem_pkg::axi_addr_t  s_awaddr,
	input  axi_mem_pkg::axi_len_t   s_awlen,
	input  axi_mem_pkg::axi_size_t  s_awsize,
	input  logic                    s_awvalid,
	output logic                    s_awready,

	input  axi_mem_pkg::axi_data_t  s_wdata,
	input  axi_mem_pkg::axi_strb_t  s_wstrb,
	input  logic                    s_wlast,
	input  logic                    s_wvalid,
	output logic                    s_wready,

	output axi_mem_pkg::axi_id_t    s_bid,
	output axi_mem_pkg::axi_resp_t  s_bresp,
	output logic                    s_bvalid,
	input  logic                    s_bready,

	input  axi_mem_pkg::axi_id_t    s_arid,
	input  axi_mem_pkg::axi_addr_t  s_araddr,
	input  axi_mem_pkg::axi_len_t   s_arlen,
	input  axi_mem_pkg::axi_size_t  s_arsize,
	input  logic                    s_arvalid,
	output logic                    s_arready,

	output axi_mem_pkg::axi_id_t    s_rid,
	output axi_mem_pkg::axi_data_t  s_rdata,
	output axi_mem_pkg::axi_resp_t  s_rresp,
	output logic                    s_rlast,
	output logic                    s_rvalid,
	input  logic                    s_rready
);

	import axi_mem_pkg::*;

	addr_req_t  aw_in, aw_out, ar_in, ar_out;
	w_beat_t    w_in, w_out;
	r_beat_t    r_in, r_out;
	logic       aw_valid, aw_ready, w_valid, w_ready;
	logic       ar_valid, ar_ready, r_valid;
	logic [$clog2(`R_FIFO_DEPTH+1)-1:0] r_free;

	logic       wr_req, wr_gnt, rd_req, rd_gnt;
	mem_idx_t   wr_idx, rd_idx;
	axi_data_t  wr_data, rd_data;
	axi_strb_t  wr_strb;

	// ------------------------------
	// channel FIFOs
	// ------------------------------
	assign aw_in.id   = s_awid;
	assign aw_in.addr = s_awaddr;
	assign aw_in.len  = s_awlen;
	assign aw_in.size = s_awsize;

	assign w_in.data = s_wdata;
	assign w_in.strb = s_wstrb;
	assign w_in.last = s_wlast;

	assign ar_in.id   = s_arid;
	assign ar_in.addr = s_araddr;
	assign ar_in.len  = s_arlen;
	assign ar_in.size = s_arsize;

	chan_fifo #(.payload_t(addr_req_t), .DEPTH(`CHAN_FIFO_DEPTH)) u_aw_fifo (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(aw_in), .in_valid(s_awvalid), .in_ready(s_awready),
		.out_data(aw_out), .out_valid(aw_valid), .out_ready(aw_ready),
		.free_count()
	);

	chan_fifo #(.payload_t(w_beat_t), .DEPTH(`CHAN_FIFO_DEPTH)) u_w_fifo (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(w_in), .in_valid(s_wvalid), .in_ready(s_wready),
		.out_data(w_out), .out_valid(w_valid), .out_ready(w_ready),
		.free_count()
	);

	chan_fifo #(.payload_t(addr_req_t), .DEPTH(`CHAN_FIFO_DEPTH)) u_ar_fifo (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(ar_in), .in_valid(s_arvalid), .in_ready(s_arready),
		.out_data(ar_out), .out_valid(ar_valid), .out_ready(ar_ready),
		.free_count()
	);

	// read engine only pushes when free_count allows
	chan_fifo #(.payload_t(r_beat_t), .DEPTH(`R_FIFO_DEPTH)) u_r_fifo (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(r_in), .in_valid(r_valid), .in_ready(),
		.out_data(r_out), .out_valid(s_rvalid), .out_ready(s_rready),
		.free_count(r_free)
	);

	assign s_rid   = r_out.id;
	assign s_rdata = r_out.data;
	assign s_rlast = r_out.last;
	assign s_rresp = OKAY;

	// ------------------------------
	// engines and memory
	// ------------------------------
	axi_write_engine u_write_engine (
		.aclk(aclk), .aresetn(aresetn),
		.aw_req(aw_out), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w_beat(w_out), .w_valid(w_valid), .w_ready(w_ready),
		.bid(s_bid), .bresp(s_bresp), .bvalid(s_bvalid), .bready(s_bready),
		.wr_req(wr_req), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb),
		.wr_gnt(wr_gnt)
	);

	axi_read_engine u_read_engine (
		.aclk(aclk), .aresetn(aresetn),
		.ar_req(ar_out), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.rd_req(rd_req), .rd_idx(rd_idx), .rd_gnt(rd_gnt), .rd_data(rd_data),
		.r_beat(r_in), .r_valid(r_valid), .r_free(r_free)
	);

	mem_arbiter_ram u_mem (
		.aclk(aclk),
		.wr_req(wr_req), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb),
		.wr_gnt(wr_gnt),
		.rd_req(rd_req), .rd_idx(rd_idx), .rd_gnt(rd_gnt), .rd_data(rd_data)
	);

endmodule

// File: sim/tb_axi_mem_slave.sv
/*
 * Testbench for the AXI4 slave memory that runs a table of bursts with
 * random B/R back-pressure against a byte reference memory
 */

`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module tb_axi_mem_slave;

	import axi_mem_pkg::*;

	localparam int          BYTES    = 1 << `AXI_BYTES_LOG2;
	localparam int          NUM_TXNS = 15;
	localparam logic [31:0] SEED     = 32'hba32_3d76;

	// direction, overlap with next row, burst fields and data seed per row
	typedef struct packed {
		logic       is_wr;
		logic       overlap;
		axi_id_t    id;
		axi_addr_t  addr;
		axi_len_t   len;
		axi_size_t  size;
		axi_strb_t  strb;
		logic [31:0] dseed;
	} txn_t;

	txn_t txns [NUM_TXNS] = '{
		'{1'b1, 1'b0, 4'd1,  32'h0000_0100, 8'd0,  3'd2, 4'hf, 32'h11},
		'{1'b0, 1'b0, 4'd2,  32'h0000_0100, 8'd0,  3'd2, 4'h0, 32'h00},
		'{1'b1, 1'b0, 4'd3,  32'h0000_0200, 8'd7,  3'd2, 4'hf, 32'h22},
		'{1'b0, 1'b0, 4'd4,  32'h0000_0200, 8'd7,  3'd2, 4'h0, 32'h00},
		'{1'b1, 1'b0, 4'd5,  32'h0000_0204, 8'd1,  3'd2, 4'h5, 32'h33},
		'{1'b1, 1'b0, 4'd6,  32'h0000_0212, 8'd3,  3'd1, 4'hf, 32'h44},
		'{1'b0, 1'b0, 4'd7,  32'h0000_0200, 8'd7,  3'd2, 4'h0, 32'h00},
		'{1'b1, 1'b0, 4'd8,  32'h0000_0400, 8'd15, 3'd2, 4'hf, 32'h55},
		'{1'b1, 1'b1, 4'd9,  32'h0000_0800, 8'd15, 3'd2, 4'hf, 32'h66},
		'{1'b0, 1'b0, 4'd10, 32'h0000_0400, 8'd15, 3'd2, 4'h0, 32'h00},
		'{1'b0, 1'b0, 4'd11, 32'h0000_0800, 8'd15, 3'd2, 4'h0, 32'h00},
		'{1'b1, 1'b0, 4'd12, 32'h0000_0300, 8'd3,  3'd2, 4'hf, 32'h77},
		'{1'b0, 1'b0, 4'd13, 32'h0000_1300, 8'd3,  3'd2, 4'h0, 32'h00},
		'{1'b1, 1'b0, 4'd14, 32'h0000_2f00, 8'd1,  3'd2, 4'hf, 32'h88},
		'{1'b0, 1'b0, 4'd15, 32'h0000_0f00, 8'd1,  3'd2, 4'h0, 32'h00}
	};

	logic       aclk;
	logic       aresetn;
	axi_id_t    s_awid, s_bid, s_arid, s_rid;
	axi_addr_t  s_awaddr, s_araddr;
	axi_len_t   s_awlen, s_arlen;
	axi_size_t  s_awsize, s_arsize;
	axi_data_t  s_wdata, s_rdata;
	axi_strb_t  s_wstrb;
	axi_resp_t  s_bresp, s_rresp;
	logic       s_awvalid, s_awready, s_wlast, s_wvalid, s_wready;
	logic       s_bvalid, s_bready, s_arvalid, s_arready;
	logic       s_rlast, s_rvalid, s_rready;

	// byte reference memory with one entry per byte of the 4 KiB window
	logic [7:0] ref_mem [BYTES << `MEM_IDX_W];
	int         b_seed = SEED;
	int         r_seed = ~SEED;

	axi_mem_slave u_axi_mem_slave (.*);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic axi_addr_t beat_addr(input axi_addr_t base, input axi_size_t size,
			input int k);
		axi_addr_t nbytes;
		nbytes = axi_addr_t'(1) << size;
		if (k == 0)
			return base;
		return (base / nbytes) * nbytes + axi_addr_t'(k) * nbytes;
	endfunction

	// word index wraps at the memory size
	function automatic int word_index(input axi_addr_t a);
		return int'((a >> `AXI_BYTES_LOG2) % (axi_addr_t'(1) << `MEM_IDX_W));
	endfunction

	function automatic axi_strb_t active_lanes(input axi_addr_t a, input axi_size_t size);
		axi_strb_t m;
		int        n;
		int        lo;
		n  = 1 << size;
		lo = (int'(a % axi_addr_t'(BYTES)) / n) * n;
		for (int b = 0; b < BYTES; b++)
			m[b] = (b >= lo) && (b < lo + n);
		return m;
	endfunction

	task automatic store_ref(input axi_addr_t a, input axi_data_t d, input axi_strb_t st);
		int base;
		base = word_index(a) * BYTES;
		for (int b = 0; b < BYTES; b++) begin
			if (st[b])
				ref_mem[base + b] = d[b*8 +: 8];
		end
	endtask

	function automatic axi_data_t ref_word(input axi_addr_t a);
		axi_data_t w;
		int        base;
		base = word_index(a) * BYTES;
		for (int b = 0; b < BYTES; b++)
			w[b*8 +: 8] = ref_mem[base + b];
		return w;
	endfunction

	function automatic int table_beats();
		int n;
		n = 0;
		for (int i = 0; i < NUM_TXNS; i++)
			n += int'(txns[i].len) + 1;
		return n;
	endfunction

	// ------------------------------
	// checks
	// ------------------------------
	task automatic report_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("Something failed");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_error($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	task automatic check_b(input axi_id_t id, input axi_resp_t resp, input axi_id_t exp_id);
		if (id !== exp_id || resp !== OKAY)
			report_error($sformatf("B bid %0h bresp %0h, expected bid %0h bresp %0h",
				id, resp, exp_id, OKAY));
	endtask

	task automatic check_r(input axi_id_t id, input axi_data_t data, input logic last,
			input axi_resp_t resp, input axi_id_t exp_id, input axi_data_t exp_data,
			input logic exp_last);
		if (id !== exp_id || data !== exp_data || last !== exp_last || resp !== OKAY)
			report_error($sformatf("R rid %0h data %h last %b resp %0h, expected %0h %h %b",
				id, data, last, resp, exp_id, exp_data, exp_last));
	endtask

	// ------------------------------
	// AXI master tasks
	// ------------------------------
	task automatic send_write(input txn_t t);
		axi_addr_t a;
		axi_data_t d;
		axi_strb_t st;
		int        dseed;
		int        k;
		bit        done;
		dseed     = SEED ^ t.dseed;
		s_awid    = t.id;
		s_awaddr  = t.addr;
		s_awlen   = t.len;
		s_awsize  = t.size;
		s_awvalid = 1'b1;
		while (!s_awready)
			@(negedge aclk);
		@(negedge aclk);
		s_awvalid = 1'b0;
		for (k = 0; k <= int'(t.len); k++) begin
			a  = beat_addr(t.addr, t.size, k);
			d  = $random(dseed);
			st = t.strb & active_lanes(a, t.size);
			s_wdata  = d;
			s_wstrb  = st;
			s_wlast  = (k == int'(t.len));
			s_wvalid = 1'b1;
			store_ref(a, d, st);
			while (!s_wready)
				@(negedge aclk);
			@(negedge aclk);
		end
		s_wvalid = 1'b0;
		s_wlast  = 1'b0;
		// bready low about a third of the time
		done = 1'b0;
		while (!done) begin
			s_bready = ({$random(b_seed)} % 3) != 0;
			if (s_bready && s_bvalid) begin
				check_b(s_bid, s_bresp, t.id);
				done = 1'b1;
			end
			@(negedge aclk);
		end
		s_bready = 1'b0;
	endtask

	task automatic send_read(input txn_t t);
		axi_addr_t a;
		int        k;
		s_arid    = t.id;
		s_araddr  = t.addr;
		s_arlen   = t.len;
		s_arsize  = t.size;
		s_arvalid = 1'b1;
		while (!s_arready)
			@(negedge aclk);
		@(negedge aclk);
		s_arvalid = 1'b0;
		k = 0;
		while (k <= int'(t.len)) begin
			s_rready = ({$random(r_seed)} % 3) != 0;
			if (s_rready && s_rvalid) begin
				a = beat_addr(t.addr, t.size, k);
				check_r(s_rid, s_rdata, s_rlast, s_rresp, t.id, ref_word(a),
					k == int'(t.len));
				k++;
			end
			@(negedge aclk);
		end
		s_rready = 1'b0;
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int i;
		aresetn   = 1'b0;
		s_awid    = '0;
		s_awaddr  = '0;
		s_awlen   = '0;
		s_awsize  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wlast   = 1'b0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_arid    = '0;
		s_araddr  = '0;
		s_arlen   = '0;
		s_arsize  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		repeat (8) @(negedge aclk);
		aresetn = 1'b1;
		@(negedge aclk);
		check_flag("bvalid after reset", s_bvalid, 1'b0);
		check_flag("rvalid after reset", s_rvalid, 1'b0);
		check_flag("awready after reset", s_awready, 1'b1);
		check_flag("wready after reset", s_wready, 1'b1);
		check_flag("arready after reset", s_arready, 1'b1);
		i = 0;
		while (i < NUM_TXNS) begin
			if (txns[i].is_wr && txns[i].overlap) begin
				// read of another region runs while this write streams
				fork
					send_write(txns[i]);
					send_read(txns[i + 1]);
				join
				i += 2;
			end else if (txns[i].is_wr) begin
				send_write(txns[i]);
				i++;
			end else begin
				send_read(txns[i]);
				i++;
			end
		end
		// no stray B or R beats left behind
		repeat (4) @(negedge aclk);
		check_flag("bvalid at end", s_bvalid, 1'b0);
		check_flag("rvalid at end", s_rvalid, 1'b0);
		$display("Everything OK");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		int limit;
		int cycles;
		limit  = 40 * table_beats() + 200 + 8;
		cycles = 0;
		while (cycles <= limit) begin
			@(posedge aclk);
			cycles++;
		end
		$display("Timeout: the transactions did not complete in %0d cycles", limit);
		$display("Something failed");
		$fatal(1, "simulation ran past its cycle limit");
	end

endmodule

// File: tb.f
+incdir+source
source/axi_mem_pkg.sv
source/chan_fifo.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/mem_arbiter_ram.sv
source/axi_mem_slave.sv
sim/tb_axi_mem_slave.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_mem_slave
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
